// File: Bender.yml
package:
  name: led_matrix

sources:
  - common/led_matrix_pkg.sv
  - rtl/uart_rx.sv
  - rtl/command_decoder.sv
  - rtl/frame_buffer.sv
  - matrix_scan/matrix_scan.sv
  - rtl/led_matrix_top.sv
  - target: test
    files:
      - verif/tb_led_matrix.sv

// File: common/led_matrix_pkg.sv
package led_matrix_pkg;

    // panel geometry
    localparam int pixel_width = 16;
    localparam int pixel_height = 8;
    localparam int bytes_per_pixel = 2;
    localparam int brightness_levels = 5;     // bit planes per frame

    // timing
    localparam int clks_per_bit = 8;          // uart oversampling
    localparam int base_on_cycles = 4;        // plane 0 on-time, doubles per plane

    // derived widths
    localparam int col_bits = $clog2(pixel_width);
    localparam int row_bits = $clog2(pixel_height);
    localparam int byte_sel_bits = $clog2(bytes_per_pixel);
    localparam int byte_addr_bits = row_bits + col_bits + byte_sel_bits;
    localparam int pixel_addr_bits = row_bits + col_bits;
    localparam int plane_bits = $clog2(brightness_levels);
    localparam int on_count_bits = $clog2(base_on_cycles << (brightness_levels - 1));
    localparam int baud_count_bits = $clog2(clks_per_bit);

    // uart receiver states
    localparam logic [1:0] rx_idle = 2'd0;
    localparam logic [1:0] rx_start = 2'd1;
    localparam logic [1:0] rx_bits = 2'd2;
    localparam logic [1:0] rx_stop = 2'd3;

    // command decoder states
    localparam logic [1:0] cmd_idle = 2'd0;
    localparam logic [1:0] cmd_wait_row = 2'd1;
    localparam logic [1:0] cmd_load = 2'd2;

    // scanner states
    localparam logic [1:0] scan_fetch = 2'd0;
    localparam logic [1:0] scan_shift = 2'd1;
    localparam logic [1:0] scan_latch = 2'd2;
    localparam logic [1:0] scan_display = 2'd3;

    // one stored pixel, written as bytes and scanned as colour fields
    typedef union packed {
        logic [0:bytes_per_pixel-1][7:0] bytes;   // bytes[0] is the high byte
        struct packed {
            logic [4:0] red;
            logic [5:0] green;                    // plane p uses green bit p+1
            logic [4:0] blue;
        } rgb;
    } pixel_t;

endpackage

// File: list.f
common/led_matrix_pkg.sv
rtl/uart_rx.sv
rtl/command_decoder.sv
rtl/frame_buffer.sv
matrix_scan/matrix_scan.sv
rtl/led_matrix_top.sv
verif/tb_led_matrix.sv

// File: matrix_scan/matrix_scan.sv
`timescale 1ns/1ns

module matrix_scan import led_matrix_pkg::*; (
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic [2:0]                   rgb_enable,
    input  logic [brightness_levels-1:0] brightness_enable,
    output logic [pixel_addr_bits-1:0]   rd_addr,
    input  pixel_t                       rd_pixel,
    output logic [2:0]                   rgb_data,
    output logic [row_bits-1:0]          row_address,
    output logic                         pixel_clk,
    output logic                         latch,
    output logic                         output_enable
);

    logic [1:0]               state;
    logic [row_bits-1:0]      row;
    logic [plane_bits-1:0]    plane;
    logic [col_bits-1:0]      col;
    logic [col_bits-1:0]      fetch_col;
    logic                     phase;          // 0 clock low, 1 clock high
    logic                     fetch_wait;
    logic [on_count_bits-1:0] on_count;
    logic                     plane_lit;
    logic [2:0]               next_rgb;

    // one column ahead while shifting, column 0 otherwise
    assign fetch_col = (state == scan_shift) ? col + 1'b1 : '0;
    assign rd_addr = {row, fetch_col};

    always_comb begin
        plane_lit = brightness_enable[plane];
        next_rgb[0] = rd_pixel.rgb.red[plane] & rgb_enable[0] & plane_lit;
        next_rgb[1] = rd_pixel.rgb.green[plane + 1'b1] & rgb_enable[1] & plane_lit;
        next_rgb[2] = rd_pixel.rgb.blue[plane] & rgb_enable[2] & plane_lit;
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= scan_fetch;
            row <= '0;
            plane <= '0;
            col <= '0;
            phase <= 1'b0;
            fetch_wait <= 1'b0;
            on_count <= '0;
            rgb_data <= '0;
            row_address <= '0;
            pixel_clk <= 1'b0;
            latch <= 1'b0;
            output_enable <= 1'b0;
        end else begin
            case (state)
                scan_fetch: begin                  // wait out the ram latency
                    fetch_wait <= 1'b1;
                    if (fetch_wait) begin
                        fetch_wait <= 1'b0;
                        col <= '0;
                        phase <= 1'b0;
                        pixel_clk <= 1'b0;
                        rgb_data <= next_rgb;
                        state <= scan_shift;
                    end
                end
                scan_shift: begin
                    phase <= ~phase;
                    pixel_clk <= ~phase;           // rising edge with data held
                    if (phase) begin
                        if (col == col_bits'(pixel_width - 1)) begin
                            latch <= 1'b1;
                            row_address <= row;    // panel is dark here
                            state <= scan_latch;
                        end else begin
                            col <= col + 1'b1;
                            rgb_data <= next_rgb;
                        end
                    end
                end
                scan_latch: begin
                    latch <= 1'b0;
                    output_enable <= 1'b1;
                    on_count <= on_count_bits'((base_on_cycles << plane) - 1);
                    state <= scan_display;
                end
                default: begin                     // binary weighted on-time
                    if (on_count == '0) begin
                        output_enable <= 1'b0;
                        state <= scan_fetch;
                        if (plane == plane_bits'(brightness_levels - 1)) begin
                            plane <= '0;
                            row <= (row == row_bits'(pixel_height - 1)) ? '0 : row + 1'b1;
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end else begin
                        on_count <= on_count - 1'b1;
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk_in) disable iff (reset) !(latch && output_enable));

endmodule

// File: rtl/command_decoder.sv
`timescale 1ns/1ns

module command_decoder import led_matrix_pkg::*; (
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic [7:0]                   rx_data,
    input  logic                         rx_valid,
    output logic [2:0]                   rgb_enable,
    output logic [brightness_levels-1:0] brightness_enable,
    output logic [byte_addr_bits-1:0]    wr_addr,
    output logic [7:0]                   wr_data,
    output logic                         wr_en
);

    logic [1:0]               state;
    logic [row_bits-1:0]      line_row;
    logic [col_bits-1:0]      line_col;
    logic [byte_sel_bits-1:0] byte_idx;
    logic                     last_byte;

    assign last_byte = (line_col == col_bits'(pixel_width - 1)) &&
                       (byte_idx == byte_sel_bits'(bytes_per_pixel - 1));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= cmd_idle;
            rgb_enable <= '1;
            brightness_enable <= '1;
            line_row <= '0;
            line_col <= '0;
            byte_idx <= '0;
            wr_en <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            if (rx_valid) begin
                case (state)
                    cmd_idle: begin
                        case (rx_data)
                            "R": rgb_enable[0] <= 1'b1;
                            "r": rgb_enable[0] <= 1'b0;
                            "G": rgb_enable[1] <= 1'b1;
                            "g": rgb_enable[1] <= 1'b0;
                            "B": rgb_enable[2] <= 1'b1;
                            "b": rgb_enable[2] <= 1'b0;
                            // digit k flips plane brightness_levels - k
                            "1": brightness_enable[brightness_levels - 1] <=
                                     ~brightness_enable[brightness_levels - 1];
                            "2": brightness_enable[brightness_levels - 2] <=
                                     ~brightness_enable[brightness_levels - 2];
                            "3": brightness_enable[brightness_levels - 3] <=
                                     ~brightness_enable[brightness_levels - 3];
                            "4": brightness_enable[brightness_levels - 4] <=
                                     ~brightness_enable[brightness_levels - 4];
                            "5": brightness_enable[brightness_levels - 5] <=
                                     ~brightness_enable[brightness_levels - 5];
                            "0": brightness_enable <= '0;
                            "9": brightness_enable <= '1;
                            "L": state <= cmd_wait_row;
                            default: state <= cmd_idle;     // unknown byte, no effect
                        endcase
                    end
                    cmd_wait_row: begin
                        if (rx_data != "L") begin               // repeated L keeps waiting
                            line_row <= rx_data[row_bits-1:0];
                            line_col <= '0;
                            byte_idx <= '0;
                            state <= cmd_load;
                        end
                    end
                    cmd_load: begin
                        wr_en <= 1'b1;
                        if (byte_idx == byte_sel_bits'(bytes_per_pixel - 1)) begin
                            byte_idx <= '0;
                            line_col <= line_col + 1'b1;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                        if (last_byte) begin
                            state <= cmd_idle;
                        end
                    end
                    default: state <= cmd_idle;
                endcase
            end
        end
    end

    // write payload, address is row then column then byte index
    always_ff @(posedge clk_in) begin
        if (rx_valid && state == cmd_load) begin
            wr_data <= rx_data;
            wr_addr <= {line_row, line_col, byte_idx};
        end
    end

    assert property (@(posedge clk_in) disable iff (reset)
        wr_en |-> $past(rx_valid && state == cmd_load));

endmodule

// File: rtl/frame_buffer.sv
`timescale 1ns/1ns

module frame_buffer import led_matrix_pkg::*; (
    input  logic                       clk_in,
    input  logic [byte_addr_bits-1:0]  wr_addr,
    input  logic [7:0]                 wr_data,
    input  logic                       wr_en,
    input  logic [pixel_addr_bits-1:0] rd_addr,
    output pixel_t                     rd_pixel
);

    logic [pixel_addr_bits-1:0] wr_pixel;
    logic [byte_sel_bits-1:0]   wr_byte;

    // one bank per byte of the pixel
    logic [7:0] bank [bytes_per_pixel][2**pixel_addr_bits];

    assign wr_pixel = wr_addr[byte_addr_bits-1:byte_sel_bits];
    assign wr_byte = wr_addr[byte_sel_bits-1:0];

    always_ff @(posedge clk_in) begin
        for (int b = 0; b < bytes_per_pixel; b++) begin
            if (wr_en && wr_byte == byte_sel_bits'(b)) begin
                bank[b][wr_pixel] <= wr_data;
            end
            rd_pixel.bytes[b] <= bank[b][rd_addr];   // both bytes in one read
        end
    end

endmodule

// File: rtl/led_matrix_top.sv
`timescale 1ns/1ns

module led_matrix_top import led_matrix_pkg::*; (
    input  logic                clk_in,
    input  logic                reset,
    input  logic                serial_in,
    output logic [2:0]          rgb_data,
    output logic [row_bits-1:0] row_address,
    output logic                pixel_clk,
    output logic                latch,
    output logic                output_enable
);

    logic [7:0]                   rx_data;
    logic                         rx_valid;
    logic [2:0]                   rgb_enable;
    logic [brightness_levels-1:0] brightness_enable;
    logic [byte_addr_bits-1:0]    wr_addr;
    logic [7:0]                   wr_data;
    logic                         wr_en;
    logic [pixel_addr_bits-1:0]   rd_addr;
    pixel_t                       rd_pixel;

    uart_rx uart_rx0 (
        .clk_in    (clk_in),
        .reset     (reset),
        .serial_in (serial_in),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid)
    );

    command_decoder command_decoder0 (
        .clk_in            (clk_in),
        .reset             (reset),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .wr_en             (wr_en)
    );

    frame_buffer frame_buffer0 (
        .clk_in   (clk_in),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_en    (wr_en),
        .rd_addr  (rd_addr),
        .rd_pixel (rd_pixel)
    );

    matrix_scan matrix_scan0 (
        .clk_in            (clk_in),
        .reset             (reset),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .rd_addr           (rd_addr),
        .rd_pixel          (rd_pixel),
        .rgb_data          (rgb_data),
        .row_address       (row_address),
        .pixel_clk         (pixel_clk),
        .latch             (latch),
        .output_enable     (output_enable)
    );

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/1ns

module uart_rx import led_matrix_pkg::*; (
    input  logic       clk_in,
    input  logic       reset,
    input  logic       serial_in,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    logic                       serial_meta;
    logic                       serial_sync;
    logic [1:0]                 state;
    logic [baud_count_bits-1:0] clk_count;
    logic [2:0]                 bit_count;

    // two-flop synchroniser, line idles high
    always_ff @(posedge clk_in) begin
        if (reset) begin
            serial_meta <= 1'b1;
            serial_sync <= 1'b1;
        end else begin
            serial_meta <= serial_in;
            serial_sync <= serial_meta;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= rx_idle;
            clk_count <= '0;
            bit_count <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                rx_idle: begin
                    clk_count <= '0;
                    if (!serial_sync) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin                          // re-check start at mid bit
                    if (clk_count == baud_count_bits'(clks_per_bit / 2 - 1)) begin
                        clk_count <= '0;
                        bit_count <= '0;
                        state <= serial_sync ? rx_idle : rx_bits;
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                rx_bits: begin
                    if (clk_count == baud_count_bits'(clks_per_bit - 1)) begin
                        clk_count <= '0;
                        bit_count <= bit_count + 1'b1;
                        if (bit_count == 3'd7) begin
                            state <= rx_stop;
                        end
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                default: begin                           // stop bit
                    if (clk_count == baud_count_bits'(clks_per_bit - 1)) begin
                        rx_valid <= serial_sync;         // framing error drops the byte
                        state <= rx_idle;
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb first, sampled at mid bit
    always_ff @(posedge clk_in) begin
        if (state == rx_bits && clk_count == baud_count_bits'(clks_per_bit - 1)) begin
            rx_data <= {serial_sync, rx_data[7:1]};
        end
    end

    assert property (@(posedge clk_in) disable iff (reset) rx_valid |=> !rx_valid);

endmodule

// File: verif/tb_led_matrix.sv
`timescale 1ns/1ns

module tb_led_matrix import led_matrix_pkg::*; ();

    localparam int frame_timeout = 20000;       // clocks, one frame is about 2500

    logic       clk_in;
    logic       reset;
    logic       serial_in;
    logic [2:0] rgb_data;
    logic [2:0] row_address;
    logic       pixel_clk;
    logic       latch;
    logic       output_enable;

    // model of what the decoder should hold
    logic [7:0] model_mem [pixel_height][pixel_width][bytes_per_pixel];
    logic [2:0] model_rgb_en;
    logic [brightness_levels-1:0] model_bright;
    int         model_state;                    // 0 idle, 1 wait row, 2 load
    int         model_row;
    int         model_col;
    int         model_idx;

    // monitor state
    logic [2:0] cols [pixel_width];
    logic       prev_pclk, prev_latch, prev_oe;
    logic [2:0] prev_row_address;
    int         col_count, oe_count;
    int         scan_row, scan_plane, lit_row, lit_plane;
    int         frames_done;
    bit         checking;

    led_matrix_top dut0 (
        .clk_in        (clk_in),
        .reset         (reset),
        .serial_in     (serial_in),
        .rgb_data      (rgb_data),
        .row_address   (row_address),
        .pixel_clk     (pixel_clk),
        .latch         (latch),
        .output_enable (output_enable)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s (got %0h, expected %0h)",
                     $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail_now(input string what);
        $display("%s at %0t ns", what, $time);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // panel bits for one column of one plane, from the pixel bit layout
    function automatic logic [2:0] expected_rgb(input int row, input int plane, input int col);
        logic [15:0] pixel;
        logic        lit;
        logic [2:0]  result;
        pixel = {model_mem[row][col][0], model_mem[row][col][1]};   // byte 0 is high
        lit = model_bright[plane];
        result[0] = pixel[11 + plane] & model_rgb_en[0] & lit;     // red 15:11
        result[1] = pixel[6 + plane] & model_rgb_en[1] & lit;      // green 10:5, bit p+1
        result[2] = pixel[plane] & model_rgb_en[2] & lit;          // blue 4:0
        return result;
    endfunction

    task automatic update_model(input logic [7:0] value);
        int digit;
        digit = int'(value) - int'("0");
        case (model_state)
            0: begin
                case (value)
                    "R": model_rgb_en[0] = 1'b1;
                    "r": model_rgb_en[0] = 1'b0;
                    "G": model_rgb_en[1] = 1'b1;
                    "g": model_rgb_en[1] = 1'b0;
                    "B": model_rgb_en[2] = 1'b1;
                    "b": model_rgb_en[2] = 1'b0;
                    "1", "2", "3", "4", "5":
                        model_bright[brightness_levels - digit] =
                            ~model_bright[brightness_levels - digit];
                    "0": model_bright = '0;
                    "9": model_bright = '1;
                    "L": model_state = 1;
                    default: model_state = 0;
                endcase
            end
            1: begin
                if (value != "L") begin
                    model_row = int'(value[2:0]);
                    model_col = 0;
                    model_idx = 0;
                    model_state = 2;
                end
            end
            default: begin
                model_mem[model_row][model_col][model_idx] = value;
                if (model_idx == bytes_per_pixel - 1) begin
                    model_idx = 0;
                    model_col++;
                end else begin
                    model_idx++;
                end
                if (model_col == pixel_width) model_state = 0;
            end
        endcase
    endtask

    // 8n1 frame, lsb first, then wait for the receiver's strobe
    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame_bits;
        bit         got_strobe;
        int         waited;
        frame_bits = {1'b1, value, 1'b0};
        got_strobe = 1'b0;
        waited = 0;
        for (int i = 0; i < 10; i++) begin
            for (int j = 0; j < clks_per_bit; j++) begin
                @(negedge clk_in);
                if (j == 0) serial_in = frame_bits[i];
                if (dut0.rx_valid) got_strobe = 1'b1;
            end
        end
        while (!got_strobe) begin
            @(negedge clk_in);
            if (dut0.rx_valid) begin
                got_strobe = 1'b1;
            end else begin
                waited++;
                if (waited > 3 * clks_per_bit) begin
                    fail_now($sformatf("No byte strobe from the receiver for byte %h", value));
                end
            end
        end
        update_model(value);
        repeat (2 * clks_per_bit) @(negedge clk_in);   // idle line between bytes
    endtask

    task automatic load_row(input logic [7:0] row_byte);
        send_byte("L");
        send_byte(row_byte);
        repeat (pixel_width * bytes_per_pixel) send_byte(8'($urandom));
    endtask

    task automatic wait_frame_end;
        int start_count;
        int cycles;
        start_count = frames_done;
        cycles = 0;
        while (frames_done == start_count) begin
            @(posedge clk_in);
            cycles++;
            if (cycles > frame_timeout) fail_now("Timed out waiting for the end of a panel frame");
        end
    endtask

    // compare one complete scan that starts after all commands took effect
    task automatic check_frame;
        wait_frame_end();
        checking = 1'b1;
        wait_frame_end();
        checking = 1'b0;
    endtask

    always @(negedge clk_in) begin : panel_monitor
        if (reset) begin
            prev_pclk = 1'b0;
            prev_latch = 1'b0;
            prev_oe = 1'b0;
            prev_row_address = '0;
            col_count = 0;
            oe_count = 0;
            scan_row = 0;
            scan_plane = 0;
            lit_row = 0;
            lit_plane = 0;
        end else begin
            check_equal(latch & output_enable, 0, "latch and output_enable high together");
            if (pixel_clk && !prev_pclk) begin
                if (col_count < pixel_width) cols[col_count] = rgb_data;
                col_count++;
            end
            if (latch && !prev_latch) begin
                check_equal(col_count, pixel_width, "pixel_clk pulses before latch");
                if (checking) begin
                    for (int c = 0; c < pixel_width; c++) begin
                        check_equal(cols[c], expected_rgb(scan_row, scan_plane, c),
                            $sformatf("rgb_data row %0d plane %0d column %0d",
                                      scan_row, scan_plane, c));
                    end
                end
                lit_row = scan_row;
                lit_plane = scan_plane;
                col_count = 0;
                oe_count = 0;
                if (scan_plane == brightness_levels - 1) begin
                    scan_plane = 0;
                    scan_row = (scan_row + 1) % pixel_height;
                    if (scan_row == 0) frames_done++;
                end else begin
                    scan_plane++;
                end
            end
            if (output_enable) begin
                if (prev_oe) begin
                    check_equal(row_address, prev_row_address, "row_address moved while lit");
                end else begin
                    check_equal(row_address, lit_row, "row_address at start of display");
                end
                oe_count++;
            end
            if (prev_oe && !output_enable) begin
                check_equal(oe_count, base_on_cycles << lit_plane, "output_enable on-time");
            end
            prev_pclk = pixel_clk;
            prev_latch = latch;
            prev_oe = output_enable;
            prev_row_address = row_address;
        end
    end

    initial begin : stimulus
        int seed_value;
        reset = 1'b1;
        serial_in = 1'b1;
        checking = 1'b0;
        frames_done = 0;
        model_rgb_en = '1;
        model_bright = '1;
        model_state = 0;
        model_row = 0;
        model_col = 0;
        model_idx = 0;
        seed_value = $urandom(72);
        repeat (4) @(negedge clk_in);
        reset = 1'b0;

        for (int r = 0; r < pixel_height; r++) load_row(8'(r));
        check_frame();

        // colour channel enables
        send_byte("r");
        check_frame();
        send_byte("g");
        check_frame();
        send_byte("b");
        check_frame();
        send_byte("R");
        send_byte("G");
        send_byte("B");
        check_frame();

        // brightness planes, one digit at a time
        for (int k = 1; k <= brightness_levels; k++) begin
            send_byte(8'("0" + k));
            check_frame();
        end
        send_byte("9");
        check_frame();
        send_byte("3");
        check_frame();
        send_byte("0");
        check_frame();
        send_byte("9");

        // repeated L, row byte with high bits set, then junk in idle
        send_byte("L");
        load_row(8'hfd);
        send_byte("x");
        send_byte(8'h00);
        check_frame();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
